//--- verilog/vec_pkg.sv
package vec_pkg;

    localparam int CELL_W = 8;  // width of one vector cell.
    localparam int DOT_W  = 24; // holds 16 products of 8-bit cells plus sign.

    typedef logic signed [CELL_W-1:0] cell_t;
    typedef logic signed [DOT_W-1:0]  dot_t;

    typedef logic [0:0] op_t;

    localparam op_t OP_ADD = 1'b0; // element-wise add.
    localparam op_t OP_DOT = 1'b1; // dot product.

    // both engines share this two-state control.
    typedef enum logic {
        ENG_IDLE,
        ENG_RUN
    } engine_state_t;

endpackage

//--- verilog/operand_latch.sv
`timescale 1ns/100ps

module operand_latch #(
    parameter int VECTOR_LEN = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  vec_pkg::op_t                    op,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] a,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] b,
    input  logic                            busy,
    output vec_pkg::cell_t [VECTOR_LEN-1:0] a_q,
    output vec_pkg::cell_t [VECTOR_LEN-1:0] b_q,
    output vec_pkg::op_t                    op_q,
    output logic                            add_go,
    output logic                            dot_go
);
    import vec_pkg::*;

    logic accept;

    // busy rises one cycle after the go pulse, so a pending go also blocks a start.
    assign accept = start && !busy && !add_go && !dot_go;

    // operand registers, held for the whole engine run.
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q  <= a;
            b_q  <= b;
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            add_go <= 1'b0;
            dot_go <= 1'b0;
        end else begin
            add_go <= accept && (op == OP_ADD); // one-cycle pulse.
            dot_go <= accept && (op == OP_DOT);
        end
    end

endmodule

//--- verilog/vector_add.sv
`timescale 1ns/100ps

module vector_add #(
    parameter int VECTOR_LEN = 8,
    parameter int TILING     = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            go,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] a,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] b,
    output vec_pkg::cell_t [VECTOR_LEN-1:0] sum,
    output logic                            done
);
    import vec_pkg::*;

    localparam int CNT_W = $clog2(VECTOR_LEN) + 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(VECTOR_LEN - TILING);
    localparam logic [CNT_W-1:0] STEP = CNT_W'(TILING);

    engine_state_t          state;
    logic [CNT_W-1:0]       cnt;
    cell_t [VECTOR_LEN-1:0] sum_q;
    cell_t [TILING-1:0]     tile_sum;

    // one adder per tile lane, working on cells cnt .. cnt+TILING-1.
    always_comb begin
        for (int i = 0; i < TILING; i++) begin
            tile_sum[i] = a[int'(cnt) + i] + b[int'(cnt) + i]; // wraps to 8 bits.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
            sum_q <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    cnt   <= '0;
                    state <= go ? ENG_RUN : ENG_IDLE;
                end
                ENG_RUN: begin
                    for (int i = 0; i < TILING; i++) begin
                        sum_q[int'(cnt) + i] <= tile_sum[i];
                    end
                    if (cnt == LAST) begin
                        cnt   <= '0;
                        state <= ENG_IDLE;
                        done  <= 1'b1; // registered with the final tile.
                    end else begin
                        cnt <= cnt + STEP;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    assign sum = sum_q;

endmodule

//--- verilog/vector_dot.sv
`timescale 1ns/100ps

module vector_dot #(
    parameter int VECTOR_LEN = 8,
    parameter int TILING     = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            go,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] a,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] b,
    output vec_pkg::dot_t                   dot,
    output logic                            done
);
    import vec_pkg::*;

    localparam int CNT_W = $clog2(VECTOR_LEN) + 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(VECTOR_LEN - TILING);
    localparam logic [CNT_W-1:0] STEP = CNT_W'(TILING);

    engine_state_t    state;
    logic [CNT_W-1:0] cnt;
    dot_t             acc;
    dot_t             acc_next;

    // TILING signed multipliers feeding one adder chain into the accumulator.
    always_comb begin
        cell_t ai;
        cell_t bi;
        acc_next = acc;
        for (int i = 0; i < TILING; i++) begin
            ai       = a[int'(cnt) + i];
            bi       = b[int'(cnt) + i];
            acc_next = acc_next + dot_t'(ai) * dot_t'(bi); // sign extended before the multiply.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
            cnt   <= '0;
            acc   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    cnt <= '0;
                    if (go) begin
                        acc   <= '0; // a new product sum starts from zero.
                        state <= ENG_RUN;
                    end
                end
                ENG_RUN: begin
                    acc <= acc_next;
                    if (cnt == LAST) begin
                        cnt   <= '0;
                        state <= ENG_IDLE;
                        done  <= 1'b1;
                    end else begin
                        cnt <= cnt + STEP;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    assign dot = acc;

endmodule

//--- verilog/result_hold.sv
`timescale 1ns/100ps

module result_hold #(
    parameter int VECTOR_LEN = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_ok,
    input  vec_pkg::op_t                    op_q,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] sum_in,
    input  vec_pkg::dot_t                   dot_in,
    input  logic                            add_done,
    input  logic                            dot_done,
    output vec_pkg::cell_t [VECTOR_LEN-1:0] sum,
    output vec_pkg::dot_t                   dot,
    output vec_pkg::op_t                    result_op,
    output logic                            valid,
    output logic                            busy
);
    import vec_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum       <= '0;
            dot       <= '0;
            result_op <= OP_ADD;
            valid     <= 1'b0;
            busy      <= 1'b0;
        end else begin
            if (start_ok) begin
                busy  <= 1'b1;
                valid <= 1'b0; // the old result is no longer current.
            end else if (add_done) begin
                sum       <= sum_in;
                result_op <= op_q;
                valid     <= 1'b1;
                busy      <= 1'b0;
            end else if (dot_done) begin
                dot       <= dot_in; // the sum output keeps its last add result.
                result_op <= op_q;
                valid     <= 1'b1;
                busy      <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/vector_unit.sv
`timescale 1ns/100ps

module vector_unit #(
    parameter int VECTOR_LEN = 8,
    parameter int TILING     = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  vec_pkg::op_t                    op,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] a,
    input  vec_pkg::cell_t [VECTOR_LEN-1:0] b,
    output vec_pkg::cell_t [VECTOR_LEN-1:0] sum,
    output vec_pkg::dot_t                   dot,
    output vec_pkg::op_t                    result_op,
    output logic                            valid,
    output logic                            busy
);
    import vec_pkg::*;

    cell_t [VECTOR_LEN-1:0] a_q;
    cell_t [VECTOR_LEN-1:0] b_q;
    op_t                    op_q;
    logic                   add_go;
    logic                   dot_go;
    cell_t [VECTOR_LEN-1:0] add_sum;
    logic                   add_done;
    dot_t                   dot_res;
    logic                   dot_done;

    operand_latch #(
        .VECTOR_LEN (VECTOR_LEN)
    ) u_latch (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .a_q    (a_q),
        .b_q    (b_q),
        .op_q   (op_q),
        .add_go (add_go),
        .dot_go (dot_go)
    );

    vector_add #(
        .VECTOR_LEN (VECTOR_LEN),
        .TILING     (TILING)
    ) u_add (
        .clk  (clk),
        .rst  (rst),
        .go   (add_go),
        .a    (a_q),
        .b    (b_q),
        .sum  (add_sum),
        .done (add_done)
    );

    vector_dot #(
        .VECTOR_LEN (VECTOR_LEN),
        .TILING     (TILING)
    ) u_dot (
        .clk  (clk),
        .rst  (rst),
        .go   (dot_go),
        .a    (a_q),
        .b    (b_q),
        .dot  (dot_res),
        .done (dot_done)
    );

    result_hold #(
        .VECTOR_LEN (VECTOR_LEN)
    ) u_hold (
        .clk       (clk),
        .rst       (rst),
        .start_ok  (add_go | dot_go), // a go pulse marks an accepted start.
        .op_q      (op_q),
        .sum_in    (add_sum),
        .dot_in    (dot_res),
        .add_done  (add_done),
        .dot_done  (dot_done),
        .sum       (sum),
        .dot       (dot),
        .result_op (result_op),
        .valid     (valid),
        .busy      (busy)
    );

endmodule

//--- tests/vector_unit_asserts.sv
`timescale 1ns/100ps

module vector_unit_asserts #(
    parameter int VECTOR_LEN = 8,
    parameter int TILING     = 2
) (
    input logic clk,
    input logic rst,
    input logic add_go,
    input logic dot_go,
    input logic valid,
    input logic busy
);

    localparam int LATENCY = VECTOR_LEN / TILING + 2;

    int error_count = 0;

    go_exclusive: assert property (@(posedge clk) disable iff (rst) !(add_go && dot_go))
        else begin
            $error("add_go and dot_go are high in the same cycle");
            error_count++;
        end

    add_go_pulse: assert property (@(posedge clk) disable iff (rst) add_go |=> !add_go)
        else begin
            $error("add_go lasts longer than one cycle");
            error_count++;
        end

    dot_go_pulse: assert property (@(posedge clk) disable iff (rst) dot_go |=> !dot_go)
        else begin
            $error("dot_go lasts longer than one cycle");
            error_count++;
        end

    valid_busy_apart: assert property (@(posedge clk) disable iff (rst) !(valid && busy))
        else begin
            $error("valid and busy are high together");
            error_count++;
        end

    // go lags the start edge by one cycle, and so does the sampled rise of valid.
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        (add_go || dot_go) |-> ##(LATENCY) $rose(valid))
        else begin
            $error("valid did not rise at the expected cycle after a start");
            error_count++;
        end

    busy_length: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> busy [*(LATENCY-1)] ##1 !busy)
        else begin
            $error("busy did not stay high for the whole run");
            error_count++;
        end

endmodule

bind vector_unit vector_unit_asserts #(
    .VECTOR_LEN (VECTOR_LEN),
    .TILING     (TILING)
) u_asserts (
    .clk    (clk),
    .rst    (rst),
    .add_go (add_go),
    .dot_go (dot_go),
    .valid  (valid),
    .busy   (busy)
);

//--- tests/vector_unit_tb.sv
`timescale 1ns/100ps

module vector_unit_tb;
    import vec_pkg::*;

    localparam int VECTOR_LEN     = 8;
    localparam int TILING         = 2;
    localparam int RESET_CYCLES   = 4;
    localparam int LATENCY        = VECTOR_LEN / TILING + 2;
    localparam int NUM_FIXED      = 7;
    localparam int NUM_RANDOM     = 20;
    localparam int NUM_ROWS       = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (VECTOR_LEN / TILING + 8) + RESET_CYCLES;

    // kinds of rejected start pulsed during a row.
    localparam int CLASH_NONE = 0;
    localparam int CLASH_GO   = 1; // in the go cycle, before busy rises.
    localparam int CLASH_BUSY = 2; // while busy is high.

    typedef cell_t [VECTOR_LEN-1:0] vec_t;

    logic clk;
    logic rst;
    logic start;
    op_t  op;
    vec_t a;
    vec_t b;
    vec_t sum;
    dot_t dot;
    op_t  result_op;
    logic valid;
    logic busy;

    // stimulus table, one entry per test.
    string row_name  [NUM_ROWS];
    op_t   row_op    [NUM_ROWS];
    vec_t  row_a     [NUM_ROWS];
    vec_t  row_b     [NUM_ROWS];
    bit    row_rand  [NUM_ROWS];
    int    row_clash [NUM_ROWS];

    vec_t        exp_sum;
    dot_t        exp_dot;
    logic [31:0] lfsr = 32'hf30e3d17;
    string       test_name;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    vector_unit #(
        .VECTOR_LEN (VECTOR_LEN),
        .TILING     (TILING)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .a         (a),
        .b         (b),
        .sum       (sum),
        .dot       (dot),
        .result_op (result_op),
        .valid     (valid),
        .busy      (busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2 and 1 give a maximal length sequence.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_vec(output vec_t v);
        for (int i = 0; i < VECTOR_LEN; i++) begin
            for (int k = 0; k < CELL_W; k++) begin
                lfsr    = lfsr_next(lfsr);
                v[i]    = {v[i][CELL_W-2:0], lfsr[0]};
            end
        end
    endtask

    function automatic vec_t fill_vec(input cell_t c);
        vec_t v;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            v[i] = c;
        end
        return v;
    endfunction

    function automatic vec_t ramp_vec(input int first, input int step);
        vec_t v;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            v[i] = cell_t'(first + i * step);
        end
        return v;
    endfunction

    task automatic set_row(input int r, input string name, input op_t rop,
                           input vec_t va, input vec_t vb, input bit rnd, input int clash);
        row_name[r]  = name;
        row_op[r]    = rop;
        row_a[r]     = va;
        row_b[r]     = vb;
        row_rand[r]  = rnd;
        row_clash[r] = clash;
    endtask

    task automatic build_table();
        set_row(0, "add_ramp", OP_ADD, ramp_vec(1, 1), ramp_vec(-3, 2), 0, CLASH_NONE);
        set_row(1, "add_pos_wrap", OP_ADD, fill_vec(127), fill_vec(1), 0, CLASH_NONE);
        set_row(2, "add_neg_wrap", OP_ADD, fill_vec(-128), fill_vec(-1), 0, CLASH_NONE);
        set_row(3, "dot_ramp", OP_DOT, ramp_vec(-4, 1), ramp_vec(5, -2), 0, CLASH_NONE);
        set_row(4, "dot_all_min", OP_DOT, fill_vec(-128), fill_vec(-128), 0, CLASH_NONE);
        set_row(5, "dot_go_start", OP_DOT, ramp_vec(7, -3), ramp_vec(-20, 6), 0, CLASH_GO);
        set_row(6, "add_busy_start", OP_ADD, ramp_vec(100, 9), ramp_vec(50, 11), 0,
                CLASH_BUSY);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            set_row(NUM_FIXED + k, $sformatf("lfsr_%0d", k), (k % 2 == 0) ? OP_ADD : OP_DOT,
                    '0, '0, 1, CLASH_NONE);
        end
    endtask

    // per-cell sums wrap to 8 bits, the dot product is exact.
    task automatic expect_result(input op_t rop, input vec_t va, input vec_t vb);
        int s;
        int acc;
        acc = 0;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            s          = int'(va[i]) + int'(vb[i]);
            acc        = acc + int'(va[i]) * int'(vb[i]);
            if (rop == OP_ADD) begin
                exp_sum[i] = cell_t'(s);
            end
        end
        if (rop == OP_DOT) begin
            exp_dot = dot_t'(acc);
        end
    endtask

    task automatic check_sum(input vec_t exp, input vec_t act);
        if (act !== exp) begin
            $display("Fail %s: sum expected %h actual %h", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_dot(input dot_t exp, input dot_t act);
        if (act !== exp) begin
            $display("Fail %s: dot expected %0d actual %0d", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_op(input op_t exp, input op_t act);
        if (act !== exp) begin
            $display("Fail %s: result_op expected %0d actual %0d", test_name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: pass", test_name);
            pass_count++;
        end else begin
            $display("test %s: %0d mismatches", test_name, test_errors);
            fail_count++;
        end
    endtask

    task automatic check_outputs(input op_t rop);
        check_bit("valid", 1'b1, valid);
        check_bit("busy", 1'b0, busy);
        check_sum(exp_sum, sum);
        check_dot(exp_dot, dot);
        check_op(rop, result_op);
    endtask

    task automatic run_row(input int r);
        vec_t va;
        vec_t vb;
        int   waited;
        test_name   = row_name[r];
        test_errors = 0;
        if (row_rand[r]) begin
            random_vec(va);
            random_vec(vb);
        end else begin
            va = row_a[r];
            vb = row_b[r];
        end
        expect_result(row_op[r], va, vb);
        start = 1'b1;
        op    = row_op[r];
        a     = va;
        b     = vb;
        @(negedge clk);
        if (row_clash[r] == CLASH_GO) begin
            start = 1'b1; // a pending go pulse must block this start.
            op    = ~row_op[r];
            a     = fill_vec(5);
            b     = fill_vec(-9);
        end else begin
            start = 1'b0;
            a     = ~va; // the unit holds its own copy of the operands.
            b     = ~vb;
        end
        @(negedge clk);
        waited = 1;
        start  = 1'b0;
        check_bit("busy", 1'b1, busy);
        check_bit("valid", 1'b0, valid);
        if (row_clash[r] == CLASH_BUSY) begin
            start = 1'b1; // must be ignored while busy.
            op    = ~row_op[r];
            a     = fill_vec(5);
            b     = fill_vec(-9);
            @(negedge clk);
            waited++;
            start = 1'b0;
        end
        while (!valid) begin
            @(negedge clk);
            waited++;
        end
        check_count("cycles to valid", LATENCY, waited);
        check_outputs(row_op[r]);
        repeat (2) begin
            @(negedge clk);
            check_outputs(row_op[r]);
        end
        finish_test();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        op          = OP_ADD;
        a           = '0;
        b           = '0;
        exp_sum     = '0;
        exp_dot     = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        test_name   = "reset";
        test_errors = 0;
        check_bit("valid", 1'b0, valid);
        check_bit("busy", 1'b0, busy);
        check_sum('0, sum);
        check_dot('0, dot);
        check_op(OP_ADD, result_op);
        finish_test();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, dut.u_asserts.error_count);
        if (fail_count == 0 && dut.u_asserts.error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vector_unit.f
verilog/vec_pkg.sv
verilog/operand_latch.sv
verilog/vector_add.sv
verilog/vector_dot.sv
verilog/result_hold.sv
verilog/vector_unit.sv
tests/vector_unit_asserts.sv
tests/vector_unit_tb.sv

//--- Bender.yml
package:
  name: vector_unit

sources:
  - files:
      - verilog/vec_pkg.sv
      - verilog/operand_latch.sv
      - verilog/vector_add.sv
      - verilog/vector_dot.sv
      - verilog/result_hold.sv
      - verilog/vector_unit.sv
  - target: test
    files:
      - tests/vector_unit_asserts.sv
      - tests/vector_unit_tb.sv
